//--- source/ipdc_pkg.sv
package ipdc_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int CHAN_W = 8;
	localparam int PIX_W  = 3 * CHAN_W;
	// raster index into the 8x8 image
	localparam int ADDR_W = 6;

	// one colour or luma/chroma channel
	typedef logic [CHAN_W-1:0] chan_t;
	// bits 7:0 R/Y, 15:8 G/Cb, 23:16 B/Cr
	typedef logic [PIX_W-1:0]  pixel_t;
	typedef logic [ADDR_W-1:0] pix_addr_t;

	// operation codes on i_op_mode
	typedef enum logic [2:0] {
		OP_LOAD        = 3'd0,
		OP_SHIFT_RIGHT = 3'd1,
		OP_SHIFT_DOWN  = 3'd2,
		OP_DEFAULT     = 3'd3,
		OP_ZOOM        = 3'd4,
		OP_FILTER      = 3'd5,
		OP_YCBCR       = 3'd6,
		OP_RGB         = 3'd7
	} op_mode_t;

	// ------------------------------
	// pipeline beats
	// ------------------------------
	// read request, controller to buffer
	typedef struct packed {
		logic      valid;
		pix_addr_t addr;
		logic      ycbcr;
	} rd_req_t;

	// pixel beat, buffer to formatter
	typedef struct packed {
		logic   valid;
		pixel_t pixel;
		logic   ycbcr;
	} pix_beat_t;

	// centre window origin, row 2 col 2
	localparam pix_addr_t ZOOM_ORIGIN = 6'd18;

endpackage

//--- source/image_buffer.sv
module image_buffer #(
	parameter int IMG_SIDE = 8
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_wr_en,
	input  ipdc_pkg::pix_addr_t i_wr_addr,
	input  ipdc_pkg::pixel_t    i_wr_data,
	input  ipdc_pkg::rd_req_t   i_rd_req,
	output ipdc_pkg::pix_beat_t o_beat
);

	localparam int NPIX = IMG_SIDE * IMG_SIDE;

	// ------------------------------
	// pixel store
	// ------------------------------
	// one register per pixel, raster order
	ipdc_pkg::pixel_t mem [NPIX];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NPIX; i++)
				mem[i] <= '0;
		end else if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// ------------------------------
	// read port
	// ------------------------------
	// one cycle from request to beat
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_beat <= '0;
		end else begin
			o_beat.valid <= i_rd_req.valid;
			// mode follows the beat, not the controller
			o_beat.ycbcr <= i_rd_req.ycbcr;
			o_beat.pixel <= mem[i_rd_req.addr];
		end
	end

endmodule

//--- source/pixel_formatter.sv
module pixel_formatter (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  ipdc_pkg::pix_beat_t i_beat,
	output logic                o_out_valid,
	output ipdc_pkg::pixel_t    o_out_data
);

	// clamp a signed result into one channel
	function automatic ipdc_pkg::chan_t clamp8(input logic signed [11:0] v);
		ipdc_pkg::chan_t c;
		if (v < 0)
			c = '0;
		else if (v > 255)
			c = 8'hff;
		else
			c = v[7:0];
		return c;
	endfunction

	ipdc_pkg::chan_t r, g, b;
	logic signed [11:0] r_s, g_s, b_s;
	logic signed [11:0] y_sum, cb_sum, cr_sum;
	logic signed [11:0] y_pre, cb_pre, cr_pre;
	ipdc_pkg::pixel_t ycc_pix;
	ipdc_pkg::pixel_t fmt_pix;

	// channel split, R in the low byte
	assign r = i_beat.pixel[7:0];
	assign g = i_beat.pixel[15:8];
	assign b = i_beat.pixel[23:16];

	// zero extend, room for the negative chroma terms
	assign r_s = $signed({4'b0, r});
	assign g_s = $signed({4'b0, g});
	assign b_s = $signed({4'b0, b});

	// ------------------------------
	// YCbCr
	// ------------------------------
	// Y = (2R + 5G) / 8, rounded
	assign y_sum = (r_s <<< 1) + g_s * 12'sd5 + 12'sd4;
	// Cb = (4B - R - 2G) / 8 + 128
	assign cb_sum = (b_s <<< 2) - r_s - (g_s <<< 1) + 12'sd4;
	// Cr = (4R - 3G - B) / 8 + 128
	assign cr_sum = (r_s <<< 2) - g_s * 12'sd3 - b_s + 12'sd4;

	// arithmetic shift keeps the sign
	assign y_pre  = y_sum >>> 3;
	assign cb_pre = (cb_sum >>> 3) + 12'sd128;
	assign cr_pre = (cr_sum >>> 3) + 12'sd128;

	// Cr in the high byte, Y in the low byte
	assign ycc_pix = {clamp8(cr_pre), clamp8(cb_pre), clamp8(y_pre)};

	// per-beat mode select
	assign fmt_pix = i_beat.ycbcr ? ycc_pix : i_beat.pixel;

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_out_data  <= '0;
		end else begin
			o_out_valid <= i_beat.valid;
			// data held at zero between windows
			o_out_data  <= i_beat.valid ? fmt_pix : '0;
		end
	end

endmodule

//--- source/ipdc_ctrl.sv
module ipdc_ctrl #(
	parameter int IMG_SIDE = 8,
	parameter int WIN_SIDE = 4
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_op_valid,
	input  ipdc_pkg::op_mode_t  i_op_mode,
	input  logic                i_in_valid,
	input  ipdc_pkg::pixel_t    i_in_data,
	output logic                o_in_ready,
	output logic                o_wr_en,
	output ipdc_pkg::pix_addr_t o_wr_addr,
	output ipdc_pkg::pixel_t    o_wr_data,
	output ipdc_pkg::rd_req_t   o_rd_req
);

	// ------------------------------
	// geometry
	// ------------------------------
	localparam int NPIX  = IMG_SIDE * IMG_SIDE;
	localparam int COL_W = $clog2(IMG_SIDE);
	localparam int WB    = $clog2(WIN_SIDE);
	// bits of the beat counter, 4 for a 4x4 window
	localparam int WIN_W = 2 * WB;
	// last legal origin row or column
	localparam int EDGE  = IMG_SIDE - WIN_SIDE;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SHOW
	} state_t;

	state_t              state;
	ipdc_pkg::pix_addr_t load_cnt;
	ipdc_pkg::pix_addr_t origin;
	logic                ycbcr_mode;
	logic [WIN_W-1:0]    win_cnt;

	logic                op_acc;
	logic                pix_acc;
	logic [COL_W-1:0]    org_col;
	logic [ipdc_pkg::ADDR_W-COL_W-1:0] org_row;
	logic [WB-1:0]       win_row;
	logic [WB-1:0]       win_col;
	ipdc_pkg::pix_addr_t rd_addr;

	// ready everywhere but window display
	assign o_in_ready = (state != SHOW);
	assign op_acc     = (state == IDLE) && i_op_valid;
	assign pix_acc    = (state == LOAD) && i_in_valid;

	// image write port, one pixel per accepted beat
	assign o_wr_en   = pix_acc;
	assign o_wr_addr = load_cnt;
	assign o_wr_data = i_in_data;

	// origin split into column and row
	assign org_col = origin[COL_W-1:0];
	assign org_row = origin[ipdc_pkg::ADDR_W-1:COL_W];

	// ------------------------------
	// window address
	// ------------------------------
	// beat k -> origin + (k / WIN_SIDE) * IMG_SIDE + (k % WIN_SIDE)
	assign win_row = win_cnt[WIN_W-1:WB];
	assign win_col = win_cnt[WB-1:0];
	assign rd_addr = origin + ipdc_pkg::pix_addr_t'({win_row, {COL_W{1'b0}}})
		+ ipdc_pkg::pix_addr_t'(win_col);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= IDLE;
			load_cnt   <= '0;
			origin     <= '0;
			ycbcr_mode <= 1'b0;
			win_cnt    <= '0;
			o_rd_req   <= '0;
		end else begin
			// request register idles low unless a beat goes out
			o_rd_req.valid <= 1'b0;
			case (state)
				IDLE: begin
					if (op_acc) begin
						win_cnt <= '0;
						case (i_op_mode)
							ipdc_pkg::OP_LOAD: begin
								load_cnt <= '0;
								state    <= LOAD;
							end
							ipdc_pkg::OP_SHIFT_RIGHT: begin
								// blocked at the right edge
								if (int'(org_col) < EDGE)
									origin <= origin + 1'b1;
								state <= SHOW;
							end
							ipdc_pkg::OP_SHIFT_DOWN: begin
								// one row is IMG_SIDE pixels
								if (int'(org_row) < EDGE)
									origin <= origin + ipdc_pkg::pix_addr_t'(IMG_SIDE);
								state <= SHOW;
							end
							ipdc_pkg::OP_DEFAULT: begin
								origin <= '0;
								state  <= SHOW;
							end
							ipdc_pkg::OP_ZOOM: begin
								origin <= ipdc_pkg::ZOOM_ORIGIN;
								state  <= SHOW;
							end
							// filter is accepted but does nothing
							ipdc_pkg::OP_FILTER: state <= IDLE;
							ipdc_pkg::OP_YCBCR: begin
								ycbcr_mode <= 1'b1;
								state      <= SHOW;
							end
							ipdc_pkg::OP_RGB: begin
								ycbcr_mode <= 1'b0;
								state      <= SHOW;
							end
						endcase
					end
				end
				LOAD: begin
					if (pix_acc) begin
						load_cnt <= load_cnt + 1'b1;
						// whole image in, back to idle
						if (int'(load_cnt) == NPIX - 1) begin
							load_cnt <= '0;
							state    <= IDLE;
						end
					end
				end
				SHOW: begin
					// mode bit rides with every beat
					o_rd_req.valid <= 1'b1;
					o_rd_req.addr  <= rd_addr;
					o_rd_req.ycbcr <= ycbcr_mode;
					win_cnt        <= win_cnt + 1'b1;
					if (&win_cnt)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- source/ipdc_top.sv
module ipdc_top #(
	parameter int IMG_SIDE = 8,
	parameter int WIN_SIDE = 4
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_op_valid,
	input  ipdc_pkg::op_mode_t i_op_mode,
	input  logic               i_in_valid,
	input  ipdc_pkg::pixel_t   i_in_data,
	output logic               o_in_ready,
	output logic               o_out_valid,
	output ipdc_pkg::pixel_t   o_out_data
);

	// image write port
	logic                wr_en;
	ipdc_pkg::pix_addr_t wr_addr;
	ipdc_pkg::pixel_t    wr_data;
	// pipeline beats
	ipdc_pkg::rd_req_t   rd_req;
	ipdc_pkg::pix_beat_t beat;

	// ------------------------------
	// control, origin and addresses
	// ------------------------------
	ipdc_ctrl #(
		.IMG_SIDE(IMG_SIDE),
		.WIN_SIDE(WIN_SIDE)
	) u_ctrl (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_op_valid (i_op_valid),
		.i_op_mode  (i_op_mode),
		.i_in_valid (i_in_valid),
		.i_in_data  (i_in_data),
		.o_in_ready (o_in_ready),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.o_wr_data  (wr_data),
		.o_rd_req   (rd_req)
	);

	// image store, one cycle read
	image_buffer #(
		.IMG_SIDE(IMG_SIDE)
	) u_buf (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_req  (rd_req),
		.o_beat    (beat)
	);

	// colour space and output register
	pixel_formatter u_fmt (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_beat      (beat),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

//--- dv/ipdc_assertions.sv
module ipdc_assertions (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_in_ready,
	input logic i_out_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// words seen so far in the current output run
	logic [4:0] run_len;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			run_len <= '0;
		else if (i_out_valid)
			run_len <= run_len + 5'd1;
		else
			run_len <= '0;
	end

	// ------------------------------
	// protocol
	// ------------------------------
	// no output while reset is held
	a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_out_valid)
		else $error("o_out_valid high during reset");

	// input closed for the first 13 words of a window
	// last 3 words are still in the pipeline once the controller is idle
	a_show_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_out_valid && run_len < 5'd13) |-> !i_in_ready)
		else $error("o_in_ready high while the window was shown");

	// a window is 16 words, no more
	a_run_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_out_valid |-> run_len < 5'd16)
		else $error("output run longer than 16 words");

	// and no fewer
	a_run_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!i_out_valid && run_len != 5'd0) |-> run_len == 5'd16)
		else $error("output run ended after %0d words", run_len);

endmodule

bind ipdc_top ipdc_assertions u_assert (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_in_ready  (o_in_ready),
	.i_out_valid (o_out_valid)
);

//--- dv/ipdc_tb.sv
module ipdc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMG_SIDE  = 8;
	localparam int WIN_SIDE  = 4;
	localparam int NPIX      = IMG_SIDE * IMG_SIDE;
	localparam int WIN_PIX   = WIN_SIDE * WIN_SIDE;
	// accept edge to first word: request, read, format
	localparam int PIPE_LAT  = 3;
	// missing window given up after this
	localparam int WAIT_MAX  = 10;
	// silent cycles checked after a filter op
	localparam int QUIET_CYC = 8;

	typedef struct {
		string              name;
		ipdc_pkg::op_mode_t op;
		// origin after the op, -1 where nothing is shown
		int                 origin;
	} op_entry_t;

	logic               i_clk;
	logic               i_rst_n;
	logic               i_op_valid;
	ipdc_pkg::op_mode_t i_op_mode;
	logic               i_in_valid;
	ipdc_pkg::pixel_t   i_in_data;
	logic               o_in_ready;
	logic               o_out_valid;
	ipdc_pkg::pixel_t   o_out_data;

	op_entry_t          ops [$];
	// model copy of the image, raster order
	ipdc_pkg::pixel_t   img [NPIX];
	logic               ycbcr_mode;
	int unsigned        lcg_state;
	int                 cycles;
	int                 cycle_limit;
	int                 errors;
	int                 passed;
	int                 failed;

	ipdc_top #(
		.IMG_SIDE(IMG_SIDE),
		.WIN_SIDE(WIN_SIDE)
	) dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	// 10 ns clock
	always #5 i_clk = ~i_clk;

	// run limit
	always @(posedge i_clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic ipdc_pkg::pixel_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:8];
	endfunction

	function automatic ipdc_pkg::chan_t clamp_chan(input int v);
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return v[7:0];
	endfunction

	// Y/Cb/Cr with rounding, floor shift and clamp
	function automatic ipdc_pkg::pixel_t to_ycbcr(input ipdc_pkg::pixel_t p);
		int r, g, b, y, cb, cr;
		r  = int'(p[7:0]);
		g  = int'(p[15:8]);
		b  = int'(p[23:16]);
		y  = (2 * r + 5 * g + 4) >>> 3;
		cb = ((4 * b - r - 2 * g + 4) >>> 3) + 128;
		cr = ((4 * r - 3 * g - b + 4) >>> 3) + 128;
		return {clamp_chan(cr), clamp_chan(cb), clamp_chan(y)};
	endfunction

	// word k of the window, row by row
	function automatic ipdc_pkg::pixel_t expected_word(input int origin, input int k);
		int addr;
		addr = origin + (k / WIN_SIDE) * IMG_SIDE + (k % WIN_SIDE);
		return ycbcr_mode ? to_ycbcr(img[addr]) : img[addr];
	endfunction

	// ------------------------------
	// drivers and checks
	// ------------------------------
	task automatic add_op(input string name, input ipdc_pkg::op_mode_t op, input int origin);
		op_entry_t e;
		e.name   = name;
		e.op     = op;
		e.origin = origin;
		ops.push_back(e);
	endtask

	// one cycle of i_op_valid, accepted on the next edge
	task automatic send_op(input string name, input ipdc_pkg::op_mode_t op);
		if (!o_in_ready) begin
			$display("%s: o_in_ready low when the operation was issued", name);
			errors++;
		end
		i_op_valid = 1'b1;
		i_op_mode  = op;
		@(posedge i_clk);
		#1;
		i_op_valid = 1'b0;
	endtask

	task automatic load_image(input string name, input bit with_clamp);
		for (int i = 0; i < NPIX; i++)
			img[i] = lcg_next();
		if (with_clamp) begin
			// pure blue and pure red push Cb and Cr past 255
			img[18] = 24'hff0000;
			img[1]  = 24'h0000ff;
		end
		send_op(name, ipdc_pkg::OP_LOAD);
		for (int i = 0; i < NPIX; i++) begin
			if (!o_in_ready) begin
				$display("%s: o_in_ready dropped at pixel %0d of the load", name, i);
				errors++;
			end
			i_in_valid = 1'b1;
			i_in_data  = img[i];
			@(posedge i_clk);
			#1;
		end
		i_in_valid = 1'b0;
		i_in_data  = '0;
	endtask

	// collect 16 words and compare against the model
	task automatic show_window(input string name, input int origin);
		int lat;
		ipdc_pkg::pixel_t exp_word;
		lat = 0;
		while (!o_out_valid && lat < WAIT_MAX) begin
			@(posedge i_clk);
			#1;
			lat++;
		end
		if (!o_out_valid) begin
			$display("%s: no output within %0d cycles of the operation", name, WAIT_MAX);
			errors++;
			return;
		end
		if (lat != PIPE_LAT) begin
			$display("%s: first output after %0d cycles, not %0d", name, lat, PIPE_LAT);
			errors++;
		end
		for (int k = 0; k < WIN_PIX; k++) begin
			exp_word = expected_word(origin, k);
			if (!o_out_valid) begin
				$display("%s: o_out_valid dropped at word %0d", name, k);
				errors++;
			end else if (o_out_data !== exp_word) begin
				$display("ERROR %s word %0d: expected %06h, actual %06h",
					name, k, exp_word, o_out_data);
				errors++;
			end
			@(posedge i_clk);
			#1;
		end
		if (o_out_valid) begin
			$display("%s: o_out_valid still high after %0d words", name, WIN_PIX);
			errors++;
		end else if (o_out_data !== '0) begin
			// data goes back to zero once the window is out
			$display("ERROR %s idle data: expected 000000, actual %06h",
				name, o_out_data);
			errors++;
		end
	endtask

	// nothing shown, input stays open
	task automatic check_quiet(input string name);
		repeat (QUIET_CYC) begin
			if (o_out_valid || !o_in_ready) begin
				$display("%s: output seen or o_in_ready low after the operation", name);
				errors++;
			end
			@(posedge i_clk);
			#1;
		end
	endtask

	// ------------------------------
	// operation table and run
	// ------------------------------
	initial begin
		int err_before;
		i_clk       = 1'b0;
		i_rst_n     = 1'b0;
		i_op_valid  = 1'b0;
		i_op_mode   = ipdc_pkg::OP_LOAD;
		i_in_valid  = 1'b0;
		i_in_data   = '0;
		lcg_state   = 32'd32247;
		ycbcr_mode  = 1'b0;
		cycles      = 0;
		errors      = 0;
		passed      = 0;
		failed      = 0;
		add_op("load_first", ipdc_pkg::OP_LOAD, -1);
		add_op("default_origin", ipdc_pkg::OP_DEFAULT, 0);
		add_op("right_1", ipdc_pkg::OP_SHIFT_RIGHT, 1);
		add_op("right_2", ipdc_pkg::OP_SHIFT_RIGHT, 2);
		add_op("right_3", ipdc_pkg::OP_SHIFT_RIGHT, 3);
		add_op("right_4", ipdc_pkg::OP_SHIFT_RIGHT, 4);
		add_op("right_edge", ipdc_pkg::OP_SHIFT_RIGHT, 4);
		add_op("down_1", ipdc_pkg::OP_SHIFT_DOWN, 12);
		add_op("down_2", ipdc_pkg::OP_SHIFT_DOWN, 20);
		add_op("down_3", ipdc_pkg::OP_SHIFT_DOWN, 28);
		add_op("down_4", ipdc_pkg::OP_SHIFT_DOWN, 36);
		add_op("down_edge", ipdc_pkg::OP_SHIFT_DOWN, 36);
		add_op("zoom", ipdc_pkg::OP_ZOOM, 18);
		add_op("ycbcr_zoom", ipdc_pkg::OP_YCBCR, 18);
		add_op("rgb_zoom", ipdc_pkg::OP_RGB, 18);
		add_op("default_again", ipdc_pkg::OP_DEFAULT, 0);
		add_op("ycbcr_top_left", ipdc_pkg::OP_YCBCR, 0);
		add_op("filter_none", ipdc_pkg::OP_FILTER, -1);
		add_op("load_second", ipdc_pkg::OP_LOAD, -1);
		add_op("zoom_new_image", ipdc_pkg::OP_ZOOM, 18);
		add_op("rgb_new_image", ipdc_pkg::OP_RGB, 18);
		add_op("default_new_image", ipdc_pkg::OP_DEFAULT, 0);
		cycle_limit = 40 * ops.size() + 200;

		repeat (16) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		if (!o_in_ready || o_out_valid || o_out_data !== '0) begin
			$display("outputs not at their reset values after reset");
			errors++;
		end

		foreach (ops[t]) begin
			err_before = errors;
			case (ops[t].op)
				ipdc_pkg::OP_LOAD: load_image(ops[t].name, t == 0);
				ipdc_pkg::OP_FILTER: begin
					send_op(ops[t].name, ops[t].op);
					check_quiet(ops[t].name);
				end
				default: begin
					// mode ops change the model before the window
					if (ops[t].op == ipdc_pkg::OP_YCBCR)
						ycbcr_mode = 1'b1;
					else if (ops[t].op == ipdc_pkg::OP_RGB)
						ycbcr_mode = 1'b0;
					send_op(ops[t].name, ops[t].op);
					show_window(ops[t].name, ops[t].origin);
				end
			endcase
			if (errors == err_before) begin
				passed++;
				$display("test %0d %s: pass", t, ops[t].name);
			end else begin
				failed++;
				$display("test %0d %s: fail", t, ops[t].name);
			end
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			ops.size(), passed, failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- filelist.f
source/ipdc_pkg.sv
source/image_buffer.sv
source/pixel_formatter.sv
source/ipdc_ctrl.sv
source/ipdc_top.sv
dv/ipdc_assertions.sv
dv/ipdc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ipdc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module ipdc_tb -f filelist.f -o ipdc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ipdc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
